//--- files.f
+incdir+hdl
hdl/piano_pkg.sv
hdl/note_bus_if.sv
hdl/spi_note_receiver.sv
hdl/envelope_unit.sv
hdl/voice_mixer.sv
hdl/dac_frame_control.sv
hdl/piano_top.sv
bench/piano_tb.sv

//--- run.sh
#!/bin/sh
# build the piano testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module piano_tb -f files.f -o piano_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/piano_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

//--- bench/piano_tb.sv
// Piano tone generator testbench
// sends serial note frames and decodes the DAC words coming back
`timescale 1ns/1ps
`include "piano_config.svh"

module piano_tb;

	localparam int frame_cycles = 8 * `DAC_BIT_CYCLES + `DAC_LOAD_CYCLES
		+ `DAC_LDAC_CYCLES + `DAC_IDLE_CYCLES;
	localparam int wait_limit = 4 * frame_cycles;
	localparam int pin_dclk = 0;
	localparam int pin_load = 1;
	localparam int pin_ldac = 2;

	logic clk = 1'b0;
	logic reset;
	logic sck;
	logic sdi;
	logic dclk;
	logic data;
	logic load;
	logic ldac;
	integer seed;
	int cycle = 0;
	int load_fall_cycle;

	piano_top piano_top_inst
	(
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.dclk(dclk),
		.data(data),
		.load(load),
		.ldac(ldac)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_on_error();
		$display("Checks failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected)
		else
		begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
			stop_on_error();
		end
	endtask

	function automatic logic pin_value(input int pin);
		case (pin)
			pin_dclk: return dclk;
			pin_load: return load;
			default: return ldac;
		endcase
	endfunction

	// pins are sampled on the falling clock edge
	task automatic wait_pin(input int pin, input logic level, input string what);
		int n;
		n = 0;
		while (pin_value(pin) !== level && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		assert (pin_value(pin) === level)
		else
		begin
			$display("timed out waiting for %s at %0t", what, $time);
			stop_on_error();
		end
	endtask

	// 6 reserved bits, then count, note3, note2 and note1
	function automatic logic [31:0] make_frame(input logic [1:0] count,
		input logic [7:0] n1, input logic [7:0] n2, input logic [7:0] n3);
		return {6'd0, count, n3, n2, n1};
	endfunction

	function automatic logic [7:0] expected_mix(input logic [1:0] count,
		input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
		logic [9:0] sum;
		logic [9:0] scaled;
		sum = 10'(a) + 10'(b) + 10'(c);
		case (count)
			2'd0: scaled = '0;
			2'd1: scaled = sum;
			2'd2: scaled = sum >> 1;
			default: scaled = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);
		endcase
		return scaled[7:0];
	endfunction

	// MSB first with sck low then high for 4 clk cycles each
	task automatic send_word(input logic [31:0] word);
		for (int i = 31; i >= 0; i--)
		begin
			@(posedge clk);
			sck <= 1'b0;
			sdi <= word[i];
			repeat (4) @(posedge clk);
			sck <= 1'b1;
			repeat (3) @(posedge clk);
		end
	endtask

	// leaves us in the idle gap right before a frame starts
	task automatic align_frame();
		wait_pin(pin_ldac, 1'b0, "ldac low");
		wait_pin(pin_ldac, 1'b1, "ldac high");
	endtask

	task automatic read_dac_word(output logic [7:0] word);
		logic prev;
		int n;
		int low;
		word = '0;
		for (int i = 0; i < 8; i++)
		begin
			wait_pin(pin_dclk, 1'b0, "dclk low");
			wait_pin(pin_dclk, 1'b1, "dclk rising edge");
			word = {word[6:0], data};
		end
		prev = dclk;
		n = 0;
		while (load !== 1'b0 && n < wait_limit)
		begin
			@(negedge clk);
			assert (!(dclk && !prev))
			else
			begin
				$display("more than 8 dclk pulses in one frame at %0t", $time);
				stop_on_error();
			end
			prev = dclk;
			n++;
		end
		assert (load === 1'b0)
		else
		begin
			$display("load never fell after the data bits at %0t", $time);
			stop_on_error();
		end
		load_fall_cycle = cycle;
		low = 0;
		while (load === 1'b0 && low < wait_limit)
		begin
			low++;
			@(negedge clk);
		end
		check_value("load low cycles", low, `DAC_LOAD_CYCLES);
		wait_pin(pin_ldac, 1'b0, "ldac falling edge");
		low = 0;
		while (ldac === 1'b0 && low < wait_limit)
		begin
			low++;
			@(negedge clk);
		end
		check_value("ldac low cycles", low, `DAC_LDAC_CYCLES);
	endtask

	task automatic check_words(input int count, input logic [7:0] expected, input string what);
		logic [7:0] word;
		align_frame();
		for (int i = 0; i < count; i++)
		begin
			read_dac_word(word);
			check_value(what, word, expected);
		end
	endtask

	task automatic reset_and_lock();
		// no sync word yet, so these must be ignored
		send_word(32'h03A55AC3);
		send_word(32'h02C3C35A);
		repeat (600) @(posedge clk);
		check_words(2, 8'd0, "dac word before lock");
		send_word(`SYNC_WORD);
	endtask

	task automatic sustain_one_voice();
		send_word(make_frame(2'd1, 8'd173, 8'd0, 8'd0));
		repeat (600) @(posedge clk);	// attack done
		check_words(4, 8'd173, "dac word in sustain");
	endtask

	task automatic mix_case(input logic [1:0] count);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		a = 8'($random(seed));
		b = 8'($random(seed));
		c = 8'($random(seed));
		send_word(make_frame(count, a, b, c));
		repeat (600) @(posedge clk);
		check_words(2, expected_mix(count, a, b, c), "dac word mixed");
	endtask

	task automatic envelope_shape();
		logic [7:0] word;
		logic [7:0] prev_word;
		logic [7:0] first_word;
		send_word(make_frame(2'd1, 8'd200, 8'd0, 8'd0));
		repeat (16) @(posedge clk);
		align_frame();
		prev_word = '0;
		first_word = '0;
		for (int i = 0; i < 7; i++)
		begin
			read_dac_word(word);
			if (i == 0)
				first_word = word;
			assert (word >= prev_word)
			else
			begin
				$display("attack word %0d dropped below %0d at %0t", word, prev_word, $time);
				stop_on_error();
			end
			assert (word <= 8'd200)
			else
			begin
				$display("attack word %0d is above the sustain level at %0t", word, $time);
				stop_on_error();
			end
			prev_word = word;
		end
		assert (prev_word > first_word)
		else
		begin
			$display("attack never rose, stayed at %0d", first_word);
			stop_on_error();
		end
		repeat (3200) @(posedge clk);	// rest of sustain and all of decay
		check_words(2, 8'd0, "dac word after decay");
	endtask

	task automatic retrigger();
		logic [7:0] word;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] target;
		send_word(make_frame(2'd2, 8'd120, 8'd90, 8'd60));
		repeat (2100) @(posedge clk);
		align_frame();
		read_dac_word(word);
		assert (word < expected_mix(2'd2, 8'd120, 8'd90, 8'd60))
		else
		begin
			$display("word %0d shows no decay before the retrigger", word);
			stop_on_error();
		end
		a = 8'($random(seed));
		b = 8'($random(seed));
		c = 8'($random(seed));
		target = expected_mix(2'd3, a, b, c);
		send_word(make_frame(2'd3, a, b, c));
		repeat (16) @(posedge clk);
		align_frame();
		read_dac_word(word);
		assert (word < target)
		else
		begin
			$display("word %0d after retrigger is not below the new sustain %0d", word, target);
			stop_on_error();
		end
		repeat (600) @(posedge clk);
		check_words(3, target, "dac word after retrigger");
	endtask

	// widths and pulse count are checked inside every read
	task automatic pin_protocol();
		logic [7:0] word;
		int first;
		align_frame();
		read_dac_word(word);
		first = load_fall_cycle;
		for (int i = 0; i < 3; i++)
		begin
			read_dac_word(word);
			check_value("frame period", load_fall_cycle - first, frame_cycles);
			first = load_fall_cycle;
		end
	endtask

	initial
	begin
		seed = 32'h58b1;
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("dclk", dclk, 0);
		check_value("data", data, 0);
		check_value("load", load, 1);
		check_value("ldac", ldac, 1);
		@(posedge clk);
		reset <= 1'b0;

		reset_and_lock();
		sustain_one_voice();
		mix_case(2'd2);
		mix_case(2'd3);
		mix_case(2'd0);
		envelope_shape();
		retrigger();
		pin_protocol();

		$display("All checks passed");
		$finish;
	end

endmodule

//--- hdl/piano_top.sv
// Three-voice keyboard tone generator
// serial note frames in, enveloped and mixed samples out to a serial DAC
`timescale 1ns/1ps

module piano_top
(
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	output logic dclk,
	output logic data,
	output logic load,
	output logic ldac
);
	import piano_pkg::*;

	logic env_tick;
	sample_t levels [NUM_VOICES];
	sample_t sample;

	note_bus_if note_bus ();

	spi_note_receiver receiver_inst
	(
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.bus(note_bus)
	);

	// one envelope per voice
	for (genvar v = 0; v < NUM_VOICES; v++)
	begin : g_voice
		envelope_unit #(.voice(v)) envelope_inst
		(
			.clk(clk),
			.reset(reset),
			.bus(note_bus),
			.env_tick(env_tick),
			.level(levels[v])
		);
	end

	voice_mixer mixer_inst
	(
		.bus(note_bus),
		.levels(levels),
		.sample(sample)
	);

	dac_frame_control dac_inst
	(
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.env_tick(env_tick),
		.dclk(dclk),
		.data(data),
		.load(load),
		.ldac(ldac)
	);

endmodule

//--- hdl/dac_frame_control.sv
// DAC frame sequencer
// shifts each sample out MSB first on data/dclk, then strobes load and
// ldac low; also paces the envelope ticks
`timescale 1ns/1ps
`include "piano_config.svh"

module dac_frame_control
(
	input logic clk,
	input logic reset,
	input piano_pkg::sample_t sample,
	output logic env_tick,
	output logic dclk,
	output logic data,
	output logic load,
	output logic ldac
);
	import piano_pkg::*;

	localparam int serial_cycles = 8 * `DAC_BIT_CYCLES;
	localparam int load_end = serial_cycles + `DAC_LOAD_CYCLES;
	localparam int ldac_end = load_end + `DAC_LDAC_CYCLES;
	localparam int frame_cycles = ldac_end + `DAC_IDLE_CYCLES;
	localparam int cnt_w = $clog2(frame_cycles);
	localparam int bit_w = $clog2(`DAC_BIT_CYCLES);
	localparam int tick_w = $clog2(`ENV_TICK_CYCLES);

	logic [cnt_w-1:0] cnt;
	logic [bit_w-1:0] bit_cyc;	// position inside one serial bit
	logic serial;
	logic half_high;
	sample_t shift_reg;
	logic [tick_w-1:0] tick_cnt;

	assign serial = cnt < cnt_w'(serial_cycles);
	assign half_high = bit_cyc >= bit_w'(`DAC_BIT_CYCLES / 2);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt <= '0;
			bit_cyc <= '0;
			dclk <= 1'b0;
			data <= 1'b0;
			load <= 1'b1;
			ldac <= 1'b1;
		end
		else
		begin
			if (cnt == cnt_w'(frame_cycles - 1))
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			if (serial && bit_cyc != bit_w'(`DAC_BIT_CYCLES - 1))
				bit_cyc <= bit_cyc + 1'b1;
			else
				bit_cyc <= '0;

			dclk <= serial && half_high;
			load <= !(cnt >= cnt_w'(serial_cycles) && cnt < cnt_w'(load_end));
			ldac <= !(cnt >= cnt_w'(load_end) && cnt < cnt_w'(ldac_end));

			if (cnt == '0)
				data <= sample[7];	// first bit straight from the capture
			else if (serial && bit_cyc == '0)
				data <= shift_reg[7];
			else if (!serial)
				data <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cnt == '0)
			shift_reg <= {sample[6:0], 1'b0};
		else if (serial && bit_cyc == '0)
			shift_reg <= {shift_reg[6:0], 1'b0};
	end

	// envelope step timer
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tick_cnt <= '0;
			env_tick <= 1'b0;
		end
		else
		begin
			env_tick <= tick_cnt == tick_w'(`ENV_TICK_CYCLES - 1);
			if (tick_cnt == tick_w'(`ENV_TICK_CYCLES - 1))
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	load_ldac_apart: assert property (@(posedge clk) disable iff (reset)
		!(!load && !ldac));

endmodule

//--- hdl/voice_mixer.sv
// Voice mixer
// sums the voice levels and scales the sum down by the voice count
`timescale 1ns/1ps

module voice_mixer
(
	note_bus_if.sink bus,
	input piano_pkg::sample_t levels [piano_pkg::NUM_VOICES],
	output piano_pkg::sample_t sample
);
	import piano_pkg::*;

	logic [9:0] sum;
	logic [9:0] third;

	always_comb
	begin
		sum = '0;
		for (int i = 0; i < NUM_VOICES; i++)
			sum = sum + 10'(levels[i]);
	end

	// close to sum / 3
	assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);

	always_comb
	begin
		case (bus.voice_count)
			2'd1: sample = sum[7:0];
			2'd2: sample = sum[8:1];
			2'd3: sample = third[7:0];
			default: sample = '0;	// nothing playing
		endcase
	end

endmodule

//--- hdl/envelope_unit.sv
// Voice envelope
// attack / sustain / decay gain stepped by env_tick, retriggered by each
// new frame; level is the latched note scaled by the gain
`timescale 1ns/1ps
`include "piano_config.svh"

module envelope_unit
#(
	parameter int voice = 0
)
(
	input logic clk,
	input logic reset,
	note_bus_if.sink bus,
	input logic env_tick,
	output piano_pkg::sample_t level
);
	import piano_pkg::*;

	localparam int sus_w = $clog2(`ENV_SUSTAIN_TICKS);

	env_phase_t phase;
	gain_t gain;
	logic [sus_w-1:0] sus_cnt;
	sample_t note;
	logic [8:0] attack_sum;
	logic [15:0] product;

	assign attack_sum = {1'b0, gain} + 9'(`ENV_ATTACK_STEP);
	assign product = note * gain;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= idle;
			gain <= '0;
			sus_cnt <= '0;
			note <= '0;
			level <= '0;
		end
		else
		begin
			level <= product[14:7];	// divide by 128
			if (bus.frame_strobe)
			begin
				note <= bus.notes[voice];
				phase <= attack;
				gain <= '0;
				sus_cnt <= '0;
			end
			else if (env_tick)
			begin
				case (phase)
					attack:
					begin
						if (attack_sum >= 9'(`GAIN_UNITY))
						begin
							gain <= gain_t'(`GAIN_UNITY);	// clamp at full scale
							phase <= sustain;
						end
						else
							gain <= attack_sum[7:0];
					end
					sustain:
					begin
						if (sus_cnt == sus_w'(`ENV_SUSTAIN_TICKS - 1))
							phase <= decay;
						else
							sus_cnt <= sus_cnt + 1'b1;
					end
					decay:
					begin
						gain <= gain - 8'd1;
						if (gain == 8'd1)
							phase <= idle;	// silent until the next frame
					end
					default:
						gain <= '0;
				endcase
			end
		end
	end

	gain_in_range: assert property (@(posedge clk) disable iff (reset)
		gain <= gain_t'(`GAIN_UNITY));

endmodule

//--- hdl/spi_note_receiver.sv
// Serial note receiver
// samples sck/sdi in the clk domain, locks on the sync word and
// decodes every following 32 bits as one note frame
`timescale 1ns/1ps
`include "piano_config.svh"

module spi_note_receiver
(
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	note_bus_if.source bus
);
	import piano_pkg::*;

	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic sck_prev;
	logic take_bit;
	logic locked;
	logic [4:0] bit_cnt;
	note_frame_u shift_reg;
	note_frame_u shift_next;

	// word as it will be once the current bit is in
	always_comb
	begin
		shift_next.raw = {shift_reg.raw[30:0], sdi_sync[1]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sck_sync <= '0;
			sdi_sync <= '0;
			sck_prev <= 1'b0;
			take_bit <= 1'b0;
		end
		else
		begin
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			sck_prev <= sck_sync[1];
			take_bit <= sck_sync[1] & ~sck_prev;	// one cycle after the rising edge
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_bit)
			shift_reg <= shift_next;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			locked <= 1'b0;
			bit_cnt <= '0;
			bus.frame_strobe <= 1'b0;
			bus.notes <= '{default: '0};
			bus.voice_count <= '0;
		end
		else
		begin
			bus.frame_strobe <= 1'b0;
			if (take_bit)
			begin
				if (!locked)
				begin
					if (shift_next.raw == `SYNC_WORD)
						locked <= 1'b1;	// bit count starts from here
				end
				else
				begin
					bit_cnt <= bit_cnt + 5'd1;
					if (bit_cnt == 5'(`FRAME_BITS - 1))
					begin
						bus.frame_strobe <= 1'b1;
						bus.notes[0] <= shift_next.fields.note1;
						bus.notes[1] <= shift_next.fields.note2;
						bus.notes[2] <= shift_next.fields.note3;
						bus.voice_count <= shift_next.fields.count;
					end
				end
			end
		end
	end

	strobe_needs_lock: assert property (@(posedge clk) disable iff (reset)
		bus.frame_strobe |-> locked);

endmodule

//--- hdl/note_bus_if.sv
// Decoded note frame bus
// receiver strobes a new frame, voices and mixer hold it until the next one
`timescale 1ns/1ps

interface note_bus_if;
	import piano_pkg::*;

	logic frame_strobe;	// single cycle
	sample_t notes [NUM_VOICES];
	voice_count_t voice_count;

	modport source
	(
		output frame_strobe,
		output notes,
		output voice_count
	);

	modport sink
	(
		input frame_strobe,
		input notes,
		input voice_count
	);

endinterface

//--- hdl/piano_pkg.sv
// Piano tone generator shared types
// note frame layout and envelope phase encoding
package piano_pkg;

	localparam int NUM_VOICES = 3;

	typedef logic [7:0] sample_t;	// note, level and DAC sample
	typedef logic [7:0] gain_t;	// 0 to 128
	typedef logic [1:0] voice_count_t;

	typedef enum logic [1:0]
	{
		idle,
		attack,
		sustain,
		decay
	} env_phase_t;

	// 32-bit host frame, note1 in the low byte
	typedef struct packed
	{
		logic [5:0] rsvd;
		voice_count_t count;
		sample_t note3;
		sample_t note2;
		sample_t note1;
	} note_fields_t;

	typedef union packed
	{
		logic [31:0] raw;	// checked against the sync word
		note_fields_t fields;
	} note_frame_u;

endpackage

//--- hdl/piano_config.svh
// Piano tone generator constants
// sync pattern, DAC frame timing and envelope shape
`ifndef PIANO_CONFIG_SVH
`define PIANO_CONFIG_SVH

// host link
`define SYNC_WORD 32'h0000FFFF
`define FRAME_BITS 32

// DAC frame, in clk cycles
`define DAC_BIT_CYCLES 8	// keep even, dclk toggles at half bit
`define DAC_LOAD_CYCLES 4
`define DAC_LDAC_CYCLES 4
`define DAC_IDLE_CYCLES 4

// envelope
`define ENV_TICK_CYCLES 16
`define ENV_ATTACK_STEP 4
`define ENV_SUSTAIN_TICKS 64
`define GAIN_UNITY 128	// gain is in 1/128 units

`endif
